// ==== rtl/params_pkg.sv ====
package params_pkg;

  // Data path width of the core.
  localparam int XLEN = 32;

  // Access size of a load or store. Both directions share one encoding.
  typedef logic [1:0] mem_size_t;

  localparam mem_size_t MEM_NO_DMEM_WR = 2'b00;
  localparam mem_size_t MEM_BYTE_WR    = 2'b01;
  localparam mem_size_t MEM_HALF_WR    = 2'b10;
  localparam mem_size_t MEM_WORD_WR    = 2'b11;

  // Exception cause field of mcause without the interrupt bit.
  typedef logic [30:0] trap_code_t;

  localparam trap_code_t TRAP_CODE_LOAD_ADDR_MISALIGNED  = 31'd4;
  localparam trap_code_t TRAP_CODE_STORE_ADDR_MISALIGNED = 31'd6;

endpackage

// ==== rtl/dmem_pkg.sv ====
package dmem_pkg;

  // Word-organized data RAM with four byte lanes per word.
  localparam int DMEM_WORDS  = 256;
  localparam int DMEM_IDX_W  = $clog2(DMEM_WORDS);
  localparam int DMEM_ADDR_W = DMEM_IDX_W + 2;

  typedef logic [DMEM_ADDR_W-1:0] dmem_addr_t;
  typedef logic [DMEM_IDX_W-1:0]  dmem_idx_t;

  // One enable bit per byte lane.
  typedef logic [3:0] dmem_mask_t;

endpackage

// ==== rtl/dmem_if.sv ====
`timescale 1ns/1ns

interface dmem_if;
  import params_pkg::*;
  import dmem_pkg::*;

  // Write port, owned by the store side.
  logic            we;
  dmem_mask_t      wmask;
  dmem_idx_t       widx;
  logic [XLEN-1:0] wdata;

  // Read port, owned by the load side.
  logic            re;
  dmem_idx_t       ridx;
  logic [XLEN-1:0] rdata;

  modport store_mp (output we, output wmask, output widx, output wdata);

  modport load_mp (output re, output ridx, input rdata);

  modport ram_mp (
    input  we, input wmask, input widx, input wdata,
    input  re, input ridx, output rdata
  );

endinterface

// ==== rtl/store_unit.sv ====
`timescale 1ns/1ns

module store_unit (
  input  logic                        en_i,
  input  params_pkg::mem_size_t       store_size_i,
  input  dmem_pkg::dmem_addr_t        addr_i,
  input  logic [params_pkg::XLEN-1:0] wdata_unformatted_i,
  output logic                        store_trap_o,
  output params_pkg::trap_code_t      trap_code_o,
  dmem_if.store_mp                    dmem
);
  import params_pkg::*;
  import dmem_pkg::*;

  logic [1:0]      lsb;
  logic            misaligned;
  dmem_mask_t      wmask;
  logic [XLEN-1:0] wdata_formatted;

  assign lsb = addr_i[1:0];

  // Halfwords need an even address, words a multiple of four.
  always_comb begin
    misaligned = 1'b0;
    if (en_i) begin
      case (store_size_i)
        MEM_HALF_WR: misaligned = lsb[0];
        MEM_WORD_WR: misaligned = |lsb;
        default:     misaligned = 1'b0;
      endcase
    end
  end

  // Move the store data onto the lanes it will occupy in the word.
  always_comb begin
    wmask           = '0;
    wdata_formatted = '0;
    if (en_i) begin
      case (store_size_i)
        MEM_WORD_WR: begin
          wmask           = 4'hf;
          wdata_formatted = wdata_unformatted_i;
        end
        MEM_HALF_WR: begin
          if (lsb[1]) begin
            wmask           = 4'hc;
            wdata_formatted = {wdata_unformatted_i[15:0], 16'd0};
          end else begin
            wmask           = 4'h3;
            wdata_formatted = {16'd0, wdata_unformatted_i[15:0]};
          end
        end
        MEM_BYTE_WR: begin
          wmask           = dmem_mask_t'(4'h1 << lsb);
          wdata_formatted = {4{wdata_unformatted_i[7:0]}};
        end
        default: begin
          wmask           = '0;
          wdata_formatted = '0;
        end
      endcase
    end
  end

  // A trapped store leaves the RAM untouched.
  assign dmem.wmask = misaligned ? '0 : wmask;
  assign dmem.we    = |dmem.wmask;
  assign dmem.wdata = wdata_formatted;
  assign dmem.widx  = addr_i[DMEM_ADDR_W-1:2];

  assign store_trap_o = misaligned;
  assign trap_code_o  = misaligned ? TRAP_CODE_STORE_ADDR_MISALIGNED : '0;

endmodule

// ==== rtl/load_unit.sv ====
`timescale 1ns/1ns

module load_unit (
  input  logic                        clk_i,
  input  logic                        reset_i,
  input  logic                        en_i,
  input  params_pkg::mem_size_t       load_size_i,
  input  logic                        load_unsigned_i,
  input  dmem_pkg::dmem_addr_t        addr_i,
  output logic                        load_valid_o,
  output logic [params_pkg::XLEN-1:0] load_data_o,
  output logic                        load_trap_o,
  output params_pkg::trap_code_t      trap_code_o,
  dmem_if.load_mp                     dmem
);
  import params_pkg::*;
  import dmem_pkg::*;

  logic            misaligned;
  logic            valid_q;
  logic            trap_q;
  mem_size_t       size_q;
  logic            unsigned_q;
  logic [1:0]      lsb_q;
  logic [7:0]      byte_sel;
  logic [15:0]     half_sel;
  logic [XLEN-1:0] extracted;

  // Same alignment rule as for stores.
  always_comb begin
    misaligned = 1'b0;
    if (en_i) begin
      case (load_size_i)
        MEM_HALF_WR: misaligned = addr_i[0];
        MEM_WORD_WR: misaligned = |addr_i[1:0];
        default:     misaligned = 1'b0;
      endcase
    end
  end

  assign dmem.re   = en_i & ~misaligned;
  assign dmem.ridx = addr_i[DMEM_ADDR_W-1:2];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_q <= 1'b0;
      trap_q  <= 1'b0;
    end else begin
      valid_q <= en_i;
      trap_q  <= misaligned;
    end
  end

  // These only matter while valid_q is set.
  always_ff @(posedge clk_i) begin
    if (en_i) begin
      size_q     <= load_size_i;
      unsigned_q <= load_unsigned_i;
      lsb_q      <= addr_i[1:0];
    end
  end

  assign byte_sel = dmem.rdata[8*lsb_q +: 8];
  assign half_sel = lsb_q[1] ? dmem.rdata[31:16] : dmem.rdata[15:0];

  always_comb begin
    case (size_q)
      MEM_BYTE_WR: begin
        extracted = {{24{byte_sel[7] & ~unsigned_q}}, byte_sel};
      end
      MEM_HALF_WR: begin
        extracted = {{16{half_sel[15] & ~unsigned_q}}, half_sel};
      end
      MEM_WORD_WR: begin
        extracted = dmem.rdata;
      end
      default: begin
        extracted = '0;
      end
    endcase
  end

  // A trapped load still answers, but with zero data.
  assign load_valid_o = valid_q;
  assign load_trap_o  = trap_q;
  assign load_data_o  = (valid_q && !trap_q) ? extracted : '0;
  assign trap_code_o  = trap_q ? TRAP_CODE_LOAD_ADDR_MISALIGNED : '0;

endmodule

// ==== rtl/dmem_ram.sv ====
`timescale 1ns/1ns

module dmem_ram (
  input logic clk_i,
  dmem_if.ram_mp dmem
);
  import params_pkg::*;
  import dmem_pkg::*;

  localparam int LANES = $bits(dmem_mask_t);

  logic [XLEN-1:0] mem [DMEM_WORDS];
  logic [XLEN-1:0] rdata_q;

  // Each enabled byte lane is written on its own.
  always_ff @(posedge clk_i) begin
    if (dmem.we) begin
      for (int lane = 0; lane < LANES; lane++) begin
        if (dmem.wmask[lane]) begin
          mem[dmem.widx][8*lane +: 8] <= dmem.wdata[8*lane +: 8];
        end
      end
    end
  end

  // The word at ridx appears on rdata one cycle after re.
  always_ff @(posedge clk_i) begin
    if (dmem.re) begin
      rdata_q <= mem[dmem.ridx];
    end
  end

  assign dmem.rdata = rdata_q;

endmodule

// ==== rtl/mem_stage.sv ====
`timescale 1ns/1ns

module mem_stage (
  input  logic                        clk_i,
  input  logic                        reset_i,
  input  logic                        req_valid_i,
  input  logic                        req_store_i,
  input  params_pkg::mem_size_t       req_size_i,
  input  logic                        req_unsigned_i,
  input  dmem_pkg::dmem_addr_t        req_addr_i,
  input  logic [params_pkg::XLEN-1:0] req_wdata_i,
  output logic                        store_trap_o,
  output params_pkg::trap_code_t      store_trap_code_o,
  output logic                        load_valid_o,
  output logic [params_pkg::XLEN-1:0] load_data_o,
  output logic                        load_trap_o,
  output params_pkg::trap_code_t      load_trap_code_o
);
  import params_pkg::*;

  logic mem_op;
  logic store_en;
  logic load_en;

  // A request without an access size does not touch memory.
  assign mem_op   = req_valid_i & (req_size_i != MEM_NO_DMEM_WR);
  assign store_en = mem_op & req_store_i;
  assign load_en  = mem_op & ~req_store_i;

  dmem_if dmem ();

  store_unit u_store_unit (
    .en_i                (store_en),
    .store_size_i        (req_size_i),
    .addr_i              (req_addr_i),
    .wdata_unformatted_i (req_wdata_i),
    .store_trap_o        (store_trap_o),
    .trap_code_o         (store_trap_code_o),
    .dmem                (dmem.store_mp)
  );

  load_unit u_load_unit (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .en_i            (load_en),
    .load_size_i     (req_size_i),
    .load_unsigned_i (req_unsigned_i),
    .addr_i          (req_addr_i),
    .load_valid_o    (load_valid_o),
    .load_data_o     (load_data_o),
    .load_trap_o     (load_trap_o),
    .trap_code_o     (load_trap_code_o),
    .dmem            (dmem.load_mp)
  );

  dmem_ram u_dmem_ram (
    .clk_i (clk_i),
    .dmem  (dmem.ram_mp)
  );

endmodule

// ==== tests/mem_stage_tb.sv ====
`timescale 1ns/1ns

module mem_stage_tb;
  import params_pkg::*;
  import dmem_pkg::*;

  localparam int CLK_PERIOD        = 4;
  localparam int RESET_CYCLES      = 5;
  localparam int DRIVE_DELAY       = 1;
  localparam int SAMPLE_DELAY      = 1;
  localparam int TIMEOUT_MARGIN_NS = 200;
  localparam logic [31:0] LCG_SEED = 32'hca2a_8ed7;
  localparam string TRACE_FILE     = "tests/mem_stage_trace.txt";

  typedef struct packed {
    int              line_no;
    logic            store;
    mem_size_t       size;
    logic            uns;
    dmem_addr_t      addr;
    logic [XLEN-1:0] wdata;
    logic            trap;
    logic [XLEN-1:0] data;
  } req_t;

  logic            clk_i;
  logic            reset_i;
  logic            req_valid_i;
  logic            req_store_i;
  mem_size_t       req_size_i;
  logic            req_unsigned_i;
  dmem_addr_t      req_addr_i;
  logic [XLEN-1:0] req_wdata_i;
  logic            store_trap_o;
  trap_code_t      store_trap_code_o;
  logic            load_valid_o;
  logic [XLEN-1:0] load_data_o;
  logic            load_trap_o;
  trap_code_t      load_trap_code_o;

  req_t            trace[$];
  logic            trace_loaded;
  logic [7:0]      ref_mem [DMEM_WORDS*4];
  logic            pend_valid;
  logic            pend_trap;
  logic [XLEN-1:0] pend_data;
  logic [31:0]     lcg_state;

  mem_stage DUT (
    .clk_i             (clk_i),
    .reset_i           (reset_i),
    .req_valid_i       (req_valid_i),
    .req_store_i       (req_store_i),
    .req_size_i        (req_size_i),
    .req_unsigned_i    (req_unsigned_i),
    .req_addr_i        (req_addr_i),
    .req_wdata_i       (req_wdata_i),
    .store_trap_o      (store_trap_o),
    .store_trap_code_o (store_trap_code_o),
    .load_valid_o      (load_valid_o),
    .load_data_o       (load_data_o),
    .load_trap_o       (load_trap_o),
    .load_trap_code_o  (load_trap_code_o)
  );

  always #(CLK_PERIOD/2) clk_i = ~clk_i;

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Finished with errors");
    $fatal(1, "stopped at the first error");
  endtask

  function automatic logic [31:0] next_random(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic check_store_trap(input logic exp_trap, input trap_code_t exp_code);
    if (store_trap_o !== exp_trap) begin
      fail_run($sformatf("Fail at %0t ns: store_trap_o expected %b, got %b",
                         $time, exp_trap, store_trap_o));
    end
    if (store_trap_code_o !== exp_code) begin
      fail_run($sformatf("Fail at %0t ns: store_trap_code_o expected %0d, got %0d",
                         $time, exp_code, store_trap_code_o));
    end
  endtask

  task automatic check_load(input logic exp_valid, input logic [XLEN-1:0] exp_data,
                            input logic exp_trap, input trap_code_t exp_code);
    if (load_valid_o !== exp_valid) begin
      fail_run($sformatf("Fail at %0t ns: load_valid_o expected %b, got %b",
                         $time, exp_valid, load_valid_o));
    end
    if (load_trap_o !== exp_trap) begin
      fail_run($sformatf("Fail at %0t ns: load_trap_o expected %b, got %b",
                         $time, exp_trap, load_trap_o));
    end
    if (load_trap_code_o !== exp_code) begin
      fail_run($sformatf("Fail at %0t ns: load_trap_code_o expected %0d, got %0d",
                         $time, exp_code, load_trap_code_o));
    end
    // Data only carries meaning during the response pulse.
    if (exp_valid && load_data_o !== exp_data) begin
      fail_run($sformatf("Fail at %0t ns: load_data_o expected %h, got %h",
                         $time, exp_data, load_data_o));
    end
  endtask

  // The reference memory model keeps one entry per byte address.
  function automatic logic model_misaligned(input mem_size_t size, input dmem_addr_t addr);
    case (size)
      MEM_HALF_WR: return addr[0];
      MEM_WORD_WR: return addr[1:0] != 2'b00;
      default:     return 1'b0;
    endcase
  endfunction

  task automatic model_store(input mem_size_t size, input dmem_addr_t addr,
                             input logic [XLEN-1:0] wdata);
    int n;
    case (size)
      MEM_BYTE_WR: n = 1;
      MEM_HALF_WR: n = 2;
      MEM_WORD_WR: n = 4;
      default:     n = 0;
    endcase
    for (int i = 0; i < n; i++) begin
      ref_mem[addr + dmem_addr_t'(i)] = wdata[8*i +: 8];
    end
  endtask

  function automatic logic [XLEN-1:0] model_read(input mem_size_t size, input logic uns,
                                                 input dmem_addr_t addr);
    logic [7:0] b0;
    logic [7:0] b1;
    logic [7:0] b2;
    logic [7:0] b3;
    b0 = ref_mem[addr];
    b1 = ref_mem[addr + dmem_addr_t'(1)];
    b2 = ref_mem[addr + dmem_addr_t'(2)];
    b3 = ref_mem[addr + dmem_addr_t'(3)];
    case (size)
      MEM_BYTE_WR: return {{24{b0[7] & ~uns}}, b0};
      MEM_HALF_WR: return {{16{b1[7] & ~uns}}, b1, b0};
      MEM_WORD_WR: return {b3, b2, b1, b0};
      default:     return '0;
    endcase
  endfunction

  // The trace rows must agree with the model before they are used as expectations.
  task automatic check_against_model(input req_t r);
    logic            mis;
    logic [XLEN-1:0] exp;
    mis = model_misaligned(r.size, r.addr);
    if (mis !== r.trap) begin
      fail_run($sformatf("Trace line %0d has a trap flag the reference model disagrees with",
                         r.line_no));
    end
    if (r.store) begin
      if (!mis) begin
        model_store(r.size, r.addr, r.wdata);
      end
    end else begin
      exp = mis ? '0 : model_read(r.size, r.uns, r.addr);
      if (exp !== r.data) begin
        fail_run($sformatf("Trace line %0d expects %h but the reference model gives %h",
                           r.line_no, r.data, exp));
      end
    end
  endtask

  task automatic load_trace();
    int          fd;
    int          n;
    int          line_no;
    string       line;
    logic [31:0] f_op;
    logic [31:0] f_size;
    logic [31:0] f_uns;
    logic [31:0] f_addr;
    logic [31:0] f_wdata;
    logic [31:0] f_trap;
    logic [31:0] f_data;
    req_t        r;
    fd = $fopen(TRACE_FILE, "r");
    if (fd == 0) begin
      fail_run($sformatf("Could not open the trace file %s", TRACE_FILE));
    end
    line_no = 0;
    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      line_no++;
      if (n > 0 && line.getc(0) != "#") begin
        n = $sscanf(line, "%h %h %h %h %h %h %h",
                    f_op, f_size, f_uns, f_addr, f_wdata, f_trap, f_data);
        if (n > 0 && n != 7) begin
          fail_run($sformatf("Trace line %0d has %0d fields instead of 7", line_no, n));
        end
        if (n == 7) begin
          r.line_no = line_no;
          r.store   = f_op[0];
          r.size    = f_size[1:0];
          r.uns     = f_uns[0];
          r.addr    = f_addr[DMEM_ADDR_W-1:0];
          r.wdata   = f_wdata;
          r.trap    = f_trap[0];
          r.data    = f_data;
          trace.push_back(r);
        end
      end
    end
    $fclose(fd);
    if (trace.size() == 0) begin
      fail_run("The trace file holds no requests");
    end
  endtask

  // Drive one request for a clock cycle and then check both result paths.
  task automatic run_cycle(input logic valid, input req_t r);
    @(posedge clk_i);
    #(DRIVE_DELAY);
    req_valid_i    = valid;
    req_store_i    = r.store;
    req_size_i     = r.size;
    req_unsigned_i = r.uns;
    req_addr_i     = r.addr;
    req_wdata_i    = r.wdata;
    #(SAMPLE_DELAY);
    if (valid && r.store) begin
      check_store_trap(r.trap, r.trap ? TRAP_CODE_STORE_ADDR_MISALIGNED : '0);
    end else begin
      check_store_trap(1'b0, '0);
    end
    if (pend_valid) begin
      check_load(1'b1, pend_data, pend_trap,
                 pend_trap ? TRAP_CODE_LOAD_ADDR_MISALIGNED : '0);
    end else begin
      check_load(1'b0, '0, 1'b0, '0);
    end
    pend_valid = valid && !r.store;
    pend_trap  = r.trap;
    pend_data  = r.data;
  endtask

  initial begin : watchdog
    int limit_ns;
    wait (trace_loaded);
    limit_ns = trace.size() * 4 * CLK_PERIOD + TIMEOUT_MARGIN_NS;
    #(limit_ns);
    fail_run($sformatf("Timeout: the run did not end within %0d ns", limit_ns));
  end

  initial begin : main
    req_t      idle_req;
    req_t      r;
    int        gap;
    logic      prev_was_store;
    dmem_idx_t prev_idx;
    clk_i          = 1'b0;
    reset_i        = 1'b1;
    // A misaligned load is offered during reset, and the reset must keep it from answering.
    req_valid_i    = 1'b1;
    req_store_i    = 1'b0;
    req_size_i     = MEM_WORD_WR;
    req_unsigned_i = 1'b0;
    req_addr_i     = dmem_addr_t'(1);
    req_wdata_i    = '0;
    pend_valid     = 1'b0;
    pend_trap      = 1'b0;
    pend_data      = '0;
    trace_loaded   = 1'b0;
    idle_req       = '0;
    lcg_state      = LCG_SEED;
    prev_was_store = 1'b0;
    prev_idx       = '0;

    load_trace();
    trace_loaded = 1'b1;

    for (int i = 0; i < RESET_CYCLES; i++) begin
      @(posedge clk_i);
      #(DRIVE_DELAY);
      if (i == RESET_CYCLES - 1) begin
        reset_i     = 1'b0;
        req_valid_i = 1'b0;
        req_size_i  = MEM_NO_DMEM_WR;
        req_addr_i  = '0;
      end
      #(SAMPLE_DELAY);
      check_load(1'b0, '0, 1'b0, '0);
    end

    run_cycle(1'b0, idle_req);
    run_cycle(1'b0, idle_req);

    foreach (trace[i]) begin
      r = trace[i];
      lcg_state = next_random(lcg_state);
      gap = int'((lcg_state >> 16) % 32'd3);
      // A load of the word just stored goes back-to-back to test read-after-write.
      if (prev_was_store && !r.store && prev_idx == r.addr[DMEM_ADDR_W-1:2]) begin
        gap = 0;
      end
      repeat (gap) run_cycle(1'b0, idle_req);
      check_against_model(r);
      run_cycle(1'b1, r);
      prev_was_store = r.store;
      prev_idx       = r.addr[DMEM_ADDR_W-1:2];
    end

    // Collect the last response and make sure no extra pulse follows.
    run_cycle(1'b0, idle_req);
    run_cycle(1'b0, idle_req);

    $display("Finished with no errors");
    $finish;
  end

endmodule

// ==== tests/mem_stage_trace.txt ====
# op (0 load, 1 store)  size (1 byte, 2 half, 3 word)  unsigned  addr  wdata  trap  load data
# All fields are hex. Store rows carry zero load data.
1 3 0 000 11223344 0 00000000
1 1 0 001 000000aa 0 00000000
1 2 0 002 0000beef 0 00000000
0 3 0 000 00000000 0 beefaa44
0 3 1 000 00000000 0 beefaa44
1 3 0 004 80ff7f01 0 00000000
0 1 0 004 00000000 0 00000001
0 1 0 005 00000000 0 0000007f
0 1 0 006 00000000 0 ffffffff
0 1 1 006 00000000 0 000000ff
0 1 0 007 00000000 0 ffffff80
0 1 1 007 00000000 0 00000080
0 2 0 004 00000000 0 00007f01
0 2 0 006 00000000 0 ffff80ff
0 2 1 006 00000000 0 000080ff
1 3 0 010 cafef00d 0 00000000
1 2 0 011 00001234 1 00000000
1 3 0 012 deadbeef 1 00000000
1 3 0 013 deadbeef 1 00000000
0 3 0 010 00000000 0 cafef00d
0 2 0 013 00000000 1 00000000
0 3 0 011 00000000 1 00000000
0 3 0 002 00000000 1 00000000
1 3 0 014 00000000 0 00000000
1 1 0 014 00000011 0 00000000
1 1 0 015 ffffff22 0 00000000
1 1 0 016 12345633 0 00000000
1 1 0 017 00000044 0 00000000
0 3 0 014 00000000 0 44332211
1 3 0 3fc 01020304 0 00000000
1 2 0 3fe 00005a5a 0 00000000
0 3 0 3fc 00000000 0 5a5a0304
0 2 1 3fe 00000000 0 00005a5a
0 1 0 3ff 00000000 0 0000005a
1 3 0 020 00000000 0 00000000
1 2 0 020 00008001 0 00000000
0 2 0 020 00000000 0 ffff8001
0 2 1 020 00000000 0 00008001
0 1 0 021 00000000 0 ffffff80
0 1 1 020 00000000 0 00000001

// ==== mem_stage.f ====
rtl/params_pkg.sv
rtl/dmem_pkg.sv
rtl/dmem_if.sv
rtl/store_unit.sv
rtl/load_unit.sv
rtl/dmem_ram.sv
rtl/mem_stage.sv
tests/mem_stage_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the mem_stage testbench with Verilator.
set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=mem_stage_sim
LOG_FILE=sim.log

verilator --binary --timing -sv \
  -f mem_stage.f \
  --top-module mem_stage_tb \
  -Mdir "$BUILD_DIR" \
  -o "$SIM_BIN"
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"

if grep -q "Finished with errors" "$LOG_FILE"; then
  echo "Simulation FAILED"
  exit 1
fi

if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

echo "Simulation PASSED"
exit 0
